//--- build.f
src/mul_op_pkg.sv
src/mul_dp_pkg.sv
src/mul_req_fifo.sv
src/mul_issue_ctrl.sv
src/mul_operand_prep.sv
src/booth_r4_core.sv
src/mul_result_sel.sv
src/mul_unit_top.sv
dv/mul_unit_chk.sv
dv/mul_unit_tb.sv

//--- dv/mul_unit_tb.sv
`timescale 1ns/1ps

module mul_unit_tb import mul_op_pkg::*, mul_dp_pkg::*; ();
	localparam int FIFO_DEPTH  = 4;
	localparam int OUT_CREDITS = 2;
	localparam int N_CORNER    = 60;
	localparam int N_ROWS      = 100;
	localparam int N_HELD      = FIFO_DEPTH + 2; // last rows go out with credits withheld
	localparam int WAIT_LIMIT  = 600;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	mul_op_t         in_op;
	logic [XLEN-1:0] in_src1;
	logic [XLEN-1:0] in_src2;
	logic            in_credit;
	logic            out_valid;
	logic [XLEN-1:0] out_result;
	logic            out_credit;

	mul_op_t         tbl_op   [N_ROWS];
	logic [XLEN-1:0] tbl_src1 [N_ROWS];
	logic [XLEN-1:0] tbl_src2 [N_ROWS];
	string           tbl_name [N_ROWS];

	logic [XLEN-1:0] got_q[$];  // results in arrival order
	int              sent_q[$]; // row index per accepted request
	integer          seed = 32'hb6e5;
	int              up_credits = FIFO_DEPTH;
	int              owed = 0; // downstream credits still to give back
	int              credit_pulses = 0;
	int              n_sent = 0;
	bit              hold_credits = 1'b0;
	int              n_checks = 0;
	int              n_errors = 0;

	mul_unit_top #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_mul_unit_top (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_op(in_op),
		.in_src1(in_src1), .in_src2(in_src2), .in_credit(in_credit),
		.out_valid(out_valid), .out_result(out_result), .out_credit(out_credit)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// downstream side and upstream credit tracking
	always @(posedge clk) begin
		if (out_valid) begin
			got_q.push_back(out_result);
			owed = owed + 1;
		end
		if (in_credit) begin
			up_credits = up_credits + 1;
			credit_pulses = credit_pulses + 1;
		end
		#1;
		if (!hold_credits && owed > 0) begin
			out_credit = 1'b1;
			owed = owed - 1;
		end else begin
			out_credit = 1'b0;
		end
	end

	// RISC-V M semantics on a full 128-bit product
	function automatic logic [XLEN-1:0] expected_result(mul_op_t op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] p;
		ea = {{64{a[63] && (op == OP_MULH || op == OP_MULHSU)}}, a};
		eb = {{64{b[63] && op == OP_MULH}}, b};
		p = ea * eb;
		case (op)
			OP_MUL:  return p[63:0];
			OP_MULW: return {{32{p[31]}}, p[31:0]};
			default: return p[127:64];
		endcase
	endfunction

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end else begin
			$display("pass  %s", name);
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("timeout while waiting for %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic push_row(input int idx);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		while (up_credits == 0) begin
			in_valid = 1'b0;
			if (waited == WAIT_LIMIT)
				timeout_abort("an upstream credit");
			waited++;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_op    = tbl_op[idx];
		in_src1  = tbl_src1[idx];
		in_src2  = tbl_src2[idx];
		up_credits--;
		n_sent++;
		sent_q.push_back(idx);
	endtask

	task automatic wait_results(input int n);
		int waited;
		waited = 0;
		while (got_q.size() < n) begin
			if (waited == WAIT_LIMIT)
				timeout_abort("a result on out_valid");
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic wait_credits_returned();
		int waited;
		waited = 0;
		while (owed != 0 || out_credit) begin
			if (waited == WAIT_LIMIT)
				timeout_abort("downstream credits to drain");
			waited++;
			@(negedge clk);
		end
	endtask

	// pops results in order against the rows sent
	task automatic collect_results(input int n);
		int idx;
		logic [XLEN-1:0] res;
		for (int k = 0; k < n; k++) begin
			wait_results(1);
			res = got_q.pop_front();
			idx = sent_q.pop_front();
			check_value(tbl_name[idx],
				expected_result(tbl_op[idx], tbl_src1[idx], tbl_src2[idx]), res);
		end
	endtask

	initial begin
		mul_op_t         ops [5];
		string           op_names [5];
		logic [XLEN-1:0] corner [6];
		int              o;
		int              r;
		in_valid = 1'b0;
		in_op    = OP_MUL;
		in_src1  = '0;
		in_src2  = '0;
		out_credit = 1'b0;
		rst_n    = 1'b0;
		ops      = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
		op_names = '{"mul", "mulh", "mulhsu", "mulhu", "mulw"};
		corner   = '{64'd0, 64'd1, {64{1'b1}}, 64'h8000_0000_0000_0000,
			64'h7fff_ffff_ffff_ffff, 64'h0000_0000_ffff_ffff};

		// mirrored and squared corner pairs
		for (o = 0; o < 5; o++) begin
			for (int i = 0; i < 6; i++) begin
				r = o * 12 + 2 * i;
				tbl_op[r] = ops[o];
				tbl_src1[r] = corner[i];
				tbl_src2[r] = corner[5 - i];
				tbl_name[r] = $sformatf("%s_corner_%0d", op_names[o], 2 * i);
				tbl_op[r + 1] = ops[o];
				tbl_src1[r + 1] = corner[i];
				tbl_src2[r + 1] = corner[i];
				tbl_name[r + 1] = $sformatf("%s_corner_%0d", op_names[o], 2 * i + 1);
			end
		end
		for (int k = N_CORNER; k < N_ROWS; k++) begin
			o = $unsigned($random(seed)) % 5;
			tbl_op[k] = ops[o];
			tbl_src1[k] = {$random(seed), $random(seed)};
			tbl_src2[k] = {$random(seed), $random(seed)};
			if (k % 3 == 0)
				tbl_src2[k] = {{48{tbl_src2[k][15]}}, tbl_src2[k][15:0]}; // short multiplier
			tbl_name[k] = $sformatf("%s_rand_%0d", op_names[o], k);
		end

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("reset_out_valid", 1'b0, out_valid);
		check_value("reset_in_credit", 1'b0, in_credit);

		// back-to-back stream with credits returned at once
		for (r = 0; r < N_ROWS - N_HELD; r++)
			push_row(r);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		collect_results(N_ROWS - N_HELD);

		wait_credits_returned();
		@(posedge clk);
		hold_credits = 1'b1;
		for (r = N_ROWS - N_HELD; r < N_ROWS; r++)
			push_row(r);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		wait_results(OUT_CREDITS);
		repeat (60) @(negedge clk); // nothing more may show up
		check_value("held_result_count", OUT_CREDITS, got_q.size());
		@(posedge clk);
		hold_credits = 1'b0;
		collect_results(N_HELD);

		wait_credits_returned();
		check_value("in_credit_pulses", n_sent, credit_pulses);

		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- dv/mul_unit_chk.sv
`timescale 1ns/1ps

module mul_unit_chk import mul_dp_pkg::*; #(
	parameter int OUT_CREDITS = 2
) (
	input logic            clk,
	input logic            rst_n,
	input logic            out_valid,
	input logic [XLEN-1:0] out_result,
	input logic            out_credit,
	input logic            start,
	input logic            core_busy
);
	int used; // results out whose credit is not yet back

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			used <= 0;
		else
			used <= used + int'(out_valid) - int'(out_credit);
	end

	a_out_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (used < OUT_CREDITS))
		else $error("out_valid with no downstream credit left");

	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(out_result))
		else $error("out_result carries X while out_valid is high");

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !core_busy)
		else $error("start raised while the Booth core is busy");

endmodule

bind mul_unit_top mul_unit_chk #(.OUT_CREDITS(OUT_CREDITS)) u_chk (
	.clk(clk), .rst_n(rst_n), .out_valid(out_valid), .out_result(out_result),
	.out_credit(out_credit), .start(start), .core_busy(core_busy)
);

//--- src/mul_unit_top.sv
`timescale 1ns/1ps

module mul_unit_top import mul_op_pkg::*, mul_dp_pkg::*; #(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  mul_op_t         in_op,
	input  logic [XLEN-1:0] in_src1,
	input  logic [XLEN-1:0] in_src2,
	output logic            in_credit,
	output logic            out_valid,
	output logic [XLEN-1:0] out_result,
	input  logic            out_credit
);
	logic              head_valid;
	mul_op_t           head_op;
	logic [XLEN-1:0]   head_src1;
	logic [XLEN-1:0]   head_src2;
	logic              pop;
	logic              core_busy;
	logic              start;
	logic [PROD_W-1:0] mcand;
	logic [EXT_W-1:0]  mplier;
	mul_op_t           op_q;
	logic              done;
	logic [PROD_W-1:0] product;

	mul_req_fifo #(.DEPTH(FIFO_DEPTH)) u_req_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(in_valid), .push_op(in_op), .push_src1(in_src1), .push_src2(in_src2),
		.pop(pop), .head_valid(head_valid), .head_op(head_op),
		.head_src1(head_src1), .head_src2(head_src2), .in_credit(in_credit)
	);

	mul_issue_ctrl #(.OUT_CREDITS(OUT_CREDITS)) u_issue_ctrl (
		.clk(clk), .rst_n(rst_n), .head_valid(head_valid),
		.core_busy(core_busy), .out_credit(out_credit), .pop(pop)
	);

	mul_operand_prep u_operand_prep (
		.clk(clk), .rst_n(rst_n), .pop(pop), .head_op(head_op),
		.head_src1(head_src1), .head_src2(head_src2),
		.start(start), .mcand(mcand), .mplier(mplier), .op_q(op_q)
	);

	booth_r4_core u_booth_core (
		.clk(clk), .rst_n(rst_n), .start(start), .mcand(mcand), .mplier(mplier),
		.busy(core_busy), .done(done), .product(product)
	);

	mul_result_sel u_result_sel (
		.clk(clk), .rst_n(rst_n), .done(done), .product(product), .op_q(op_q),
		.out_valid(out_valid), .out_result(out_result)
	);

endmodule

//--- src/mul_result_sel.sv
`timescale 1ns/1ps

module mul_result_sel import mul_op_pkg::*, mul_dp_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              done,
	input  logic [PROD_W-1:0] product,
	input  mul_op_t           op_q,
	output logic              out_valid,
	output logic [XLEN-1:0]   out_result
);
	logic [XLEN-1:0] res_nxt;

	always_comb begin
		if (op_takes_high(op_q))
			res_nxt = product[2*XLEN-1:XLEN];
		else if (op_q == OP_MULW)
			res_nxt = {{(XLEN - 32){product[31]}}, product[31:0]}; // word result
		else
			res_nxt = product[XLEN-1:0];
	end

	always_ff @(posedge clk) begin
		if (done)
			out_result <= res_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= done;
	end

endmodule

//--- src/booth_r4_core.sv
`timescale 1ns/1ps

module booth_r4_core import mul_dp_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic [PROD_W-1:0] mcand,
	input  logic [EXT_W-1:0]  mplier,
	output logic              busy,
	output logic              done,
	output logic [PROD_W-1:0] product
);
	booth_state_t state;
	booth_state_t state_nxt;

	logic [PROD_W-1:0] x;      // multiplicand shifted left by 2 per step
	logic [EXT_W-1:0]  y;      // multiplier bits not yet recoded
	logic              y_prev; // bit below y[0]
	logic [PROD_W-1:0] acc;
	logic [PROD_W-1:0] pp;
	logic [EXT_W-1:0]  y_nxt;
	logic              rest_uniform;

	// radix-4 recoding of {y[1], y[0], y_prev}
	always_comb begin
		case ({y[1:0], y_prev})
			3'b001, 3'b010: pp = x;
			3'b011:         pp = x << 1;
			3'b100:         pp = -(x << 1);
			3'b101, 3'b110: pp = -x;
			default:        pp = '0; // 000 and 111
		endcase
	end

	assign y_nxt = {{2{y[EXT_W-1]}}, y[EXT_W-1:2]}; // arithmetic shift

	// all remaining triplets would be 000 or 111 and add nothing
	assign rest_uniform = (&{y_nxt, y[1]}) || !(|{y_nxt, y[1]});

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start)
					state_nxt = RUN;
			end
			RUN: begin
				if (rest_uniform)
					state_nxt = LAST;
			end
			LAST:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			x      <= mcand;
			y      <= mplier;
			y_prev <= 1'b0;
			acc    <= '0;
		end else if (state == RUN) begin
			acc    <= acc + pp;
			x      <= x << 2;
			y      <= y_nxt;
			y_prev <= y[1];
		end
	end

	// acc is final while in LAST
	assign busy    = (state != IDLE);
	assign done    = (state == LAST);
	assign product = acc;

endmodule

//--- src/mul_operand_prep.sv
`timescale 1ns/1ps

module mul_operand_prep import mul_op_pkg::*, mul_dp_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              pop,
	input  mul_op_t           head_op,
	input  logic [XLEN-1:0]   head_src1,
	input  logic [XLEN-1:0]   head_src2,
	output logic              start,
	output logic [PROD_W-1:0] mcand,
	output logic [EXT_W-1:0]  mplier,
	output mul_op_t           op_q
);
	logic fill1;
	logic fill2;

	// fill bit is the sign only for signed operands
	assign fill1 = op_src1_signed(head_op) & head_src1[XLEN-1];
	assign fill2 = op_src2_signed(head_op) & head_src2[XLEN-1];

	always_ff @(posedge clk) begin
		if (pop) begin
			mcand  <= {{(PROD_W - XLEN){fill1}}, head_src1};
			mplier <= {{(EXT_W - XLEN){fill2}}, head_src2};
			op_q   <= head_op; // held until the result is selected
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= pop;
	end

endmodule

//--- src/mul_issue_ctrl.sv
`timescale 1ns/1ps

module mul_issue_ctrl #(
	parameter int OUT_CREDITS = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic head_valid,
	input  logic core_busy,
	input  logic out_credit,
	output logic pop
);
	localparam int CW = $clog2(OUT_CREDITS + 1);

	logic [CW-1:0] credit_cnt;
	logic          start_pend; // popped but core not yet busy

	// a credit is reserved at issue so the result always has a slot downstream
	assign pop = head_valid && !core_busy && !start_pend && (credit_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= CW'(OUT_CREDITS);
			start_pend <= 1'b0;
		end else begin
			case ({pop, out_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt; // both or neither
			endcase
			start_pend <= pop;
		end
	end

endmodule

//--- src/mul_req_fifo.sv
`timescale 1ns/1ps

module mul_req_fifo import mul_op_pkg::*, mul_dp_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            push,
	input  mul_op_t         push_op,
	input  logic [XLEN-1:0] push_src1,
	input  logic [XLEN-1:0] push_src2,
	input  logic            pop,
	output logic            head_valid,
	output mul_op_t         head_op,
	output logic [XLEN-1:0] head_src1,
	output logic [XLEN-1:0] head_src2,
	output logic            in_credit
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	mul_op_t         op_mem   [DEPTH];
	logic [XLEN-1:0] src1_mem [DEPTH];
	logic [XLEN-1:0] src2_mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;

	function automatic logic [AW-1:0] ptr_inc(logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1; // wraps for any depth
	endfunction

	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr]   <= push_op;
			src1_mem[wr_ptr] <= push_src1;
			src2_mem[wr_ptr] <= push_src2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			in_credit <= pop; // one credit back per popped entry
		end
	end

	assign head_valid = (count != '0);
	assign head_op    = op_mem[rd_ptr];
	assign head_src1  = src1_mem[rd_ptr];
	assign head_src2  = src2_mem[rd_ptr];

endmodule

//--- src/mul_dp_pkg.sv
package mul_dp_pkg;

	localparam int XLEN   = 64;
	localparam int EXT_W  = XLEN + 2;    // multiplier plus two sign bits
	localparam int PROD_W = 2 * EXT_W - 2; // 130 bit accumulator

	// core sequencing
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		LAST = 2'd2
	} booth_state_t;

endpackage

//--- src/mul_op_pkg.sv
package mul_op_pkg;

	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_t;

	// low product bits do not depend on signedness, so MUL/MULW go signed
	function automatic logic op_src1_signed(mul_op_t op);
		return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULW};
	endfunction

	function automatic logic op_src2_signed(mul_op_t op);
		return op inside {OP_MUL, OP_MULH, OP_MULW}; // MULHSU rs2 unsigned
	endfunction

	function automatic logic op_takes_high(mul_op_t op);
		return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
	endfunction

endpackage
